/* xbuf_top.f */
+incdir+common
common/xbuf_data_pkg.sv
common/xbuf_ctrl_pkg.sv
logic/xbuf_load_port.sv
logic/xbuf_fsm.sv
logic/xbuf_index_counters.sv
x_buffer/xbuf_pad_mem.sv
x_buffer/xbuf_bank_buffer.sv
x_buffer/xbuf_top.sv
bench/xbuf_tb.sv

/* Makefile */
# Verilator build and run for the X buffer testbench

VERILATOR ?= verilator
TOP       ?= xbuf_tb
FILELIST  ?= xbuf_top.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Testbench failed

SRCS := $(shell grep -v '^+' $(FILELIST)) common/xbuf_config.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BIN)
	@status=0; $(BIN) > $(LOG) 2>&1 || status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/xbuf_tb.sv */
/* X buffer testbench.
   Random rows and configurations checked against a tile model, with back-pressure and clear */
`timescale 1ns/1ps
`include "xbuf_config.svh"

module xbuf_tb
  import xbuf_data_pkg::*;
  import xbuf_ctrl_pkg::*;
();

  localparam int NUM_BLOCKS  = 6;
  localparam int POST_BLOCKS = 2;
  localparam int VW          = $bits(tile_t);
  // W*8 cycles to load and DEPTH*8 cycles to present per block, plus the cleared block
  localparam int WATCHDOG_NS = (NUM_BLOCKS + POST_BLOCKS + 1) *
                               (`XBUF_W * 8 + `XBUF_DEPTH * 8) * 4 + 400;

  logic        clk_i;
  logic        rst_ni;
  logic        clear_i;
  xbuf_cfg_t   cfg_i;
  logic        row_req_i;
  pad_row_t    row_data_i;
  logic        row_ack_o;
  logic        shift_i;
  tile_t       tile_o;
  logic        tile_valid_o;
  xbuf_flags_t flags_o;

  integer   seed;
  int       value_errors;
  int       other_errors;
  int       empty_seen;
  int       blocks_done;
  bit       pending;
  // Model of two blocks, the one being presented and the next one
  pad_row_t rows_m [2][`XBUF_W];
  int       slots_m [2];
  int       height_m [2];

  xbuf_top i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .cfg_i        (cfg_i),
    .row_req_i    (row_req_i),
    .row_data_i   (row_data_i),
    .row_ack_o    (row_ack_o),
    .shift_i      (shift_i),
    .tile_o       (tile_o),
    .tile_valid_o (tile_valid_o),
    .flags_o      (flags_o)
  );

  always #2 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (rst_ni && flags_o.empty) begin
      empty_seen++;
    end
  end

  task automatic report_mismatch(input string name, input logic [VW-1:0] expected,
                                 input logic [VW-1:0] actual);
    value_errors++;
    $display("FAIL %s expected %0h actual %0h at %0t", name, expected, actual, $time);
  endtask

  task automatic report_problem(input string msg);
    other_errors++;
    $display("ERROR %s at %0t", msg, $time);
  endtask

  task automatic gen_block(input int p);
    slots_m[p]  = (($random(seed) & 1) + 1) * `XBUF_H;
    height_m[p] = $unsigned($random(seed)) % (slots_m[p] + 1);
    for (int w = 0; w < `XBUF_W; w++) begin
      for (int d = 0; d < `XBUF_DEPTH; d++) begin
        rows_m[p][w][d] = elem_t'($random(seed));
      end
    end
  endtask

  task automatic raise_req(input int p, input int w);
    if (row_ack_o !== 1'b0) begin
      report_problem("row_ack_o was high before the request was raised");
    end
    cfg_i.slots  = cnt_t'(slots_m[p]);
    cfg_i.height = cnt_t'(height_m[p]);
    row_data_i   = rows_m[p][w];
    row_req_i    = 1'b1;
  endtask

  task automatic finish_row();
    @(negedge clk_i);
    while (row_ack_o !== 1'b1) begin
      @(negedge clk_i);
    end
    row_req_i = 1'b0;
    @(negedge clk_i);
    if (row_ack_o !== 1'b0) begin
      report_problem("row_ack_o did not fall one cycle after row_req_i fell");
    end
  endtask

  task automatic load_block(input int p);
    for (int w = 0; w < `XBUF_W; w++) begin
      // With an early request the first row is already on the port
      if (w != 0 || !pending) begin
        @(negedge clk_i);
        raise_req(p, w);
      end
      finish_row();
    end
    if (flags_o.full !== 1'b1) begin
      report_mismatch("full_flag", VW'(1), VW'(flags_o.full));
    end
  endtask

  function automatic tile_t expect_tile(input int p, input int t);
    tile_t e;
    int    c;
    for (int w = 0; w < `XBUF_W; w++) begin
      for (int h = 0; h < `XBUF_H; h++) begin
        c       = t * `XBUF_H + h;
        e[w][h] = (c < height_m[p]) ? rows_m[p][w][c] : '0;
      end
    end
    return e;
  endfunction

  task automatic present_block(input int p);
    int    t;
    bit    held;
    tile_t exp;
    string name;
    t    = 0;
    held = 1'b0;
    while (t < slots_m[p] / `XBUF_H) begin
      @(negedge clk_i);
      shift_i = 1'b0;
      if (pending && row_ack_o !== 1'b0) begin
        report_problem("next row was acknowledged before the block ended");
      end
      if (flags_o.empty !== 1'b0) begin
        report_problem("flags_o.empty rose before the last tile was consumed");
      end
      if (tile_valid_o === 1'b1) begin
        exp  = expect_tile(p, t);
        name = held ? "backpressure" : (height_m[p] < slots_m[p]) ? "height_pad" : "tile_data";
        if (tile_o !== exp) begin
          report_mismatch(name, exp, tile_o);
        end
        if (($random(seed) & 3) != 0) begin
          shift_i = 1'b1;
          held    = 1'b0;
          t++;
        end else begin
          held = 1'b1;
        end
      end
    end
    @(negedge clk_i);
    shift_i = 1'b0;
    if ({flags_o.full, flags_o.empty, tile_valid_o} !== 3'b010) begin
      report_mismatch("block_end", VW'(3'b010), VW'({flags_o.full, flags_o.empty, tile_valid_o}));
    end
    @(negedge clk_i);
    if (flags_o.empty !== 1'b0) begin
      report_mismatch("empty_pulse", VW'(0), VW'(flags_o.empty));
    end
  endtask

  task automatic run_blocks(input int n);
    int p;
    gen_block(0);
    pending = 1'b0;
    for (int b = 0; b < n; b++) begin
      p = b & 1;
      load_block(p);
      gen_block(p ^ 1);
      // Ask for the next block's first row early so that it has to wait for LOAD
      pending = (b < n - 1) && (($random(seed) & 1) != 0);
      if (pending) begin
        raise_req(p ^ 1, 0);
      end
      present_block(p);
      blocks_done++;
    end
  endtask

  task automatic clear_mid_block();
    gen_block(0);
    pending = 1'b0;
    load_block(0);
    while (tile_valid_o !== 1'b1) begin
      @(negedge clk_i);
    end
    repeat ($unsigned($random(seed)) % 3) @(negedge clk_i);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    if (tile_valid_o !== 1'b0) begin
      report_mismatch("clear_valid", VW'(0), VW'(tile_valid_o));
    end
    if ({flags_o.full, flags_o.empty} !== 2'b00) begin
      report_mismatch("clear_flags", VW'(0), VW'({flags_o.full, flags_o.empty}));
    end
  endtask

  initial begin
    seed         = 32'h3b59;
    value_errors = 0;
    other_errors = 0;
    empty_seen   = 0;
    blocks_done  = 0;
    pending      = 1'b0;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    cfg_i        = '0;
    row_req_i    = 1'b0;
    row_data_i   = '0;
    shift_i      = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    if (row_ack_o !== 1'b0 || tile_valid_o !== 1'b0 || flags_o !== '0) begin
      report_problem("outputs were not low after reset");
    end
    run_blocks(NUM_BLOCKS);
    clear_mid_block();
    run_blocks(POST_BLOCKS);
    if (empty_seen != blocks_done) begin
      report_mismatch("empty_count", VW'(blocks_done), VW'(empty_seen));
    end
    $display("Checks done with %0d value errors and %0d other errors",
             value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
    $display("Checks done with %0d value errors and %0d other errors",
             value_errors, other_errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* x_buffer/xbuf_top.sv */
/* X operand staging buffer.
   Loads rows into the pad and presents double-buffered tiles to the PE array */
`timescale 1ns/1ps

module xbuf_top
  import xbuf_data_pkg::*;
  import xbuf_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  xbuf_cfg_t   cfg_i,
  input  logic        row_req_i,
  input  pad_row_t    row_data_i,
  output logic        row_ack_o,
  input  logic        shift_i,
  output tile_t       tile_o,
  output logic        tile_valid_o,
  output xbuf_flags_t flags_o
);

  xbuf_cmd_t cmd;
  xbuf_idx_t idx;
  logic      row_we;
  logic      consume;
  cnt_t      height;
  pad_col_t  pad_col;

  // A tile is taken when the array shifts while it is valid
  assign consume = shift_i && tile_valid_o;

  xbuf_load_port i_load_port (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .row_req_i   (row_req_i),
    .row_ack_o   (row_ack_o),
    .accept_en_i (cmd.load_we),
    .row_we_o    (row_we)
  );

  xbuf_fsm i_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .row_we_i     (row_we),
    .idx_i        (idx),
    .shift_i      (shift_i),
    .cmd_o        (cmd),
    .tile_valid_o (tile_valid_o),
    .flags_o      (flags_o)
  );

  xbuf_index_counters i_counters (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .cfg_i     (cfg_i),
    .cmd_i     (cmd),
    .row_we_i  (row_we),
    .consume_i (consume),
    .idx_o     (idx),
    .height_o  (height)
  );

  xbuf_pad_mem i_pad (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .we_i     (row_we),
    .waddr_i  (idx.row_idx),
    .wdata_i  (row_data_i),
    .raddr_i  (idx.col_ptr),
    .height_i (height),
    .rdata_o  (pad_col)
  );

  xbuf_bank_buffer i_banks (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .we_i    (cmd.fill_we),
    .wbank_i (idx.wbank),
    .wslot_i (idx.wslot),
    .wdata_i (pad_col),
    .rbank_i (idx.rbank),
    .tile_o  (tile_o)
  );

endmodule

/* x_buffer/xbuf_bank_buffer.sv */
/* Two-bank tile buffer.
   Takes one pad column per write and shows the read bank as a W by H tile */
`timescale 1ns/1ps
`include "xbuf_config.svh"

module xbuf_bank_buffer
  import xbuf_data_pkg::*;
  import xbuf_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      we_i,
  input  logic      wbank_i,
  input  slot_idx_t wslot_i,
  input  pad_col_t  wdata_i,
  input  logic      rbank_i,
  output tile_t     tile_o
);

  pad_col_t bank_q [2][`XBUF_H];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      bank_q[wbank_i][wslot_i] <= wdata_i;
    end
  end

  // Columns are stored by slot, the tile wants width first
  always_comb begin
    for (int w = 0; w < `XBUF_W; w++) begin
      for (int h = 0; h < `XBUF_H; h++) begin
        tile_o[w][h] = bank_q[rbank_i][h][w];
      end
    end
  end

endmodule

/* x_buffer/xbuf_pad_mem.sv */
/* X buffer pad.
   W rows of pad columns, written a row at a time and read a column at a time */
`timescale 1ns/1ps
`include "xbuf_config.svh"

module xbuf_pad_mem
  import xbuf_data_pkg::*;
  import xbuf_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     we_i,
  input  row_idx_t waddr_i,
  input  pad_row_t wdata_i,
  input  col_idx_t raddr_i,
  input  cnt_t     height_i,
  output pad_col_t rdata_o
);

  pad_row_t pad_q [`XBUF_W];
  logic     in_height;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      pad_q[waddr_i] <= wdata_i;
    end
  end

  // Columns at or past height are padded with zeros
  assign in_height = cnt_t'(raddr_i) < height_i;

  always_comb begin
    for (int w = 0; w < `XBUF_W; w++) begin
      rdata_o[w] = in_height ? pad_q[w][raddr_i] : '0;
    end
  end

endmodule

/* logic/xbuf_index_counters.sv */
/* X buffer index counters.
   Row, pad column and bank pointers, bank valid bits and the consumed-column count */
`timescale 1ns/1ps
`include "xbuf_config.svh"

module xbuf_index_counters
  import xbuf_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  xbuf_cfg_t cfg_i,
  input  xbuf_cmd_t cmd_i,
  input  logic      row_we_i,
  input  logic      consume_i,
  output xbuf_idx_t idx_o,
  output cnt_t      height_o
);

  xbuf_cfg_t  cfg_q;
  row_idx_t   row_idx_q;
  col_idx_t   col_ptr_q;
  logic       fill_done_q;
  slot_idx_t  wslot_q;
  logic       wbank_q;
  logic       rbank_q;
  logic [1:0] bank_valid_q;
  cnt_t       cols_done_q;
  logic       col_wrap;
  logic       bank_wrap;

  assign col_wrap  = (cnt_t'(col_ptr_q) + cnt_t'(1)) == cfg_q.slots;
  assign bank_wrap = (wslot_q == slot_idx_t'(`XBUF_H - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q        <= '0;
      row_idx_q    <= '0;
      col_ptr_q    <= '0;
      fill_done_q  <= 1'b0;
      wslot_q      <= '0;
      wbank_q      <= 1'b0;
      rbank_q      <= 1'b0;
      bank_valid_q <= '0;
      cols_done_q  <= '0;
    end else if (clear_i) begin
      cfg_q        <= '0;
      row_idx_q    <= '0;
      col_ptr_q    <= '0;
      fill_done_q  <= 1'b0;
      wslot_q      <= '0;
      wbank_q      <= 1'b0;
      rbank_q      <= 1'b0;
      bank_valid_q <= '0;
      cols_done_q  <= '0;
    end else begin
      if (cmd_i.block_start) begin
        cfg_q       <= cfg_i;
        col_ptr_q   <= '0;
        fill_done_q <= 1'b0;
        cols_done_q <= '0;
      end
      if (row_we_i) begin
        row_idx_q <= (row_idx_q == row_idx_t'(`XBUF_W - 1)) ? '0 : row_idx_q + 1'b1;
      end
      if (cmd_i.fill_we) begin
        col_ptr_q <= col_wrap ? '0 : col_ptr_q + 1'b1;
        if (col_wrap) begin
          fill_done_q <= 1'b1;
        end
        wslot_q <= bank_wrap ? '0 : wslot_q + 1'b1;
      end
      // Read and write sides never touch the same bank in one cycle
      if (consume_i) begin
        bank_valid_q[rbank_q] <= 1'b0;
        rbank_q               <= ~rbank_q;
        cols_done_q           <= cols_done_q + cnt_t'(`XBUF_H);
      end
      if (cmd_i.fill_we && bank_wrap) begin
        bank_valid_q[wbank_q] <= 1'b1;
        wbank_q               <= ~wbank_q;
      end
    end
  end

  assign idx_o.row_idx    = row_idx_q;
  assign idx_o.col_ptr    = col_ptr_q;
  assign idx_o.wbank      = wbank_q;
  assign idx_o.wslot      = wslot_q;
  assign idx_o.rbank      = rbank_q;
  assign idx_o.cols_done  = cols_done_q;
  assign idx_o.bank_valid = bank_valid_q;
  assign idx_o.fill_done  = fill_done_q;
  assign idx_o.last_tile  = (cols_done_q == (cfg_q.slots - cnt_t'(`XBUF_H)));
  assign height_o         = cfg_q.height;

  // Rows are only written during the load phase and within the pad
  a_row_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    row_we_i |-> cmd_i.load_we && (row_idx_q <= row_idx_t'(`XBUF_W - 1))
  ) else $error("Row write outside the load phase or past the last pad row");

endmodule

/* logic/xbuf_fsm.sv */
/* X buffer controller.
   Sequences row loading, column filling and tile presentation, and raises the block flags */
`timescale 1ns/1ps
`include "xbuf_config.svh"

module xbuf_fsm
  import xbuf_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        row_we_i,
  input  xbuf_idx_t   idx_i,
  input  logic        shift_i,
  output xbuf_cmd_t   cmd_o,
  output logic        tile_valid_o,
  output xbuf_flags_t flags_o
);

  xbuf_state_e state_q, state_d;
  logic        full_q, full_d;
  logic        empty_q, empty_d;
  logic        last_row;
  logic        consume;
  logic        block_end;

  assign last_row  = row_we_i && (idx_i.row_idx == row_idx_t'(`XBUF_W - 1));
  assign consume   = shift_i && tile_valid_o;
  assign block_end = consume && idx_i.last_tile;

  always_comb begin
    state_d = state_q;
    full_d  = full_q;
    empty_d = 1'b0;
    case (state_q)
      IDLE: begin
        state_d = LOAD;
      end
      LOAD: begin
        if (last_row) begin
          full_d  = 1'b1;
          state_d = FILL;
        end
      end
      FILL, PRESENT: begin
        if (block_end) begin
          // Last tile taken, so the pad is free for the next block
          empty_d = 1'b1;
          full_d  = 1'b0;
          state_d = LOAD;
        end else if (state_q == FILL && idx_i.fill_done) begin
          state_d = PRESENT;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      full_q  <= 1'b0;
      empty_q <= 1'b0;
    end else if (clear_i) begin
      state_q <= IDLE;
      full_q  <= 1'b0;
      empty_q <= 1'b0;
    end else begin
      state_q <= state_d;
      full_q  <= full_d;
      empty_q <= empty_d;
    end
  end

  assign cmd_o.load_we     = (state_q == LOAD);
  assign cmd_o.present     = (state_q == FILL) || (state_q == PRESENT);
  // Move a column whenever the write bank is free and the pad still has columns
  assign cmd_o.fill_we     = cmd_o.present && !idx_i.fill_done &&
                             !idx_i.bank_valid[idx_i.wbank];
  assign cmd_o.block_start = cmd_o.load_we && row_we_i && (idx_i.row_idx == '0);

  assign tile_valid_o  = cmd_o.present && idx_i.bank_valid[idx_i.rbank];
  assign flags_o.full  = full_q;
  assign flags_o.empty = empty_q;

  // A tile held by the array stays valid and its bank is not refilled
  a_no_fill_on_shown_bank : assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    tile_valid_o && !shift_i |=>
      tile_valid_o && !(cmd_o.fill_we && idx_i.wbank == idx_i.rbank)
  ) else $error("Fill write into the bank being presented");

endmodule

/* logic/xbuf_load_port.sv */
/* Four-phase row receiver.
   Turns each req/ack handshake into a single pad row write */
`timescale 1ns/1ps

module xbuf_load_port (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic row_req_i,
  output logic row_ack_o,
  input  logic accept_en_i,
  output logic row_we_o
);

  // The acknowledge register is the whole receiver state
  logic ack_q;

  // A new request is taken only when the controller is loading
  assign row_we_o = row_req_i && !ack_q && accept_en_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (clear_i) begin
      ack_q <= 1'b0;
    end else if (row_we_o) begin
      ack_q <= 1'b1;
    end else if (!row_req_i) begin
      ack_q <= 1'b0;
    end
  end

  assign row_ack_o = ack_q;

  a_ack_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    !row_req_i && !row_ack_o |=> !row_ack_o
  ) else $error("Acknowledge raised without a request");

endmodule

/* common/xbuf_ctrl_pkg.sv */
/* X buffer control types.
   Run-time configuration, status flags, controller commands, counter indices and states */
`include "xbuf_config.svh"

package xbuf_ctrl_pkg;

  typedef logic [`XBUF_ROW_W-1:0]  row_idx_t;
  typedef logic [`XBUF_COL_W-1:0]  col_idx_t;
  typedef logic [`XBUF_SLOT_W-1:0] slot_idx_t;
  typedef logic [`XBUF_CNT_W-1:0]  cnt_t;

  // Slots is a nonzero multiple of H, height counts the columns that are not zeroed
  typedef struct packed {
    cnt_t slots;
    cnt_t height;
  } xbuf_cfg_t;

  typedef struct packed {
    logic full;
    logic empty;
  } xbuf_flags_t;

  typedef struct packed {
    logic load_we;
    logic fill_we;
    logic present;
    logic block_start;
  } xbuf_cmd_t;

  typedef struct packed {
    row_idx_t   row_idx;
    col_idx_t   col_ptr;
    logic       wbank;
    slot_idx_t  wslot;
    logic       rbank;
    cnt_t       cols_done;
    logic [1:0] bank_valid;
    logic       fill_done;
    logic       last_tile;
  } xbuf_idx_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    FILL,
    PRESENT
  } xbuf_state_e;

endpackage

/* common/xbuf_data_pkg.sv */
/* X buffer data types.
   Elements, pad rows and columns, and the tile shown to the array */
`include "xbuf_config.svh"

package xbuf_data_pkg;

  // One operand element
  typedef logic [`XBUF_BITW-1:0] elem_t;

  // One input row as delivered by the streamer
  typedef elem_t [`XBUF_DEPTH-1:0] pad_row_t;

  // One pad column, one element per array row
  typedef elem_t [`XBUF_W-1:0] pad_col_t;

  // Output tile, indexed by width first and height second
  typedef elem_t [`XBUF_W-1:0][`XBUF_H-1:0] tile_t;

endpackage

/* common/xbuf_config.svh */
/* X buffer configuration.
   Element width, array size and pad depth, plus the index widths derived from them */
`ifndef XBUF_CONFIG_SVH
`define XBUF_CONFIG_SVH

// Element width in bits
`define XBUF_BITW 16

// Array height, which is also the number of columns per tile
`define XBUF_H 4

// Array width, which is also the number of pad rows
`define XBUF_W 4

// Tiles per block
`define XBUF_D 2

// Pad columns
`define XBUF_DEPTH (`XBUF_H * `XBUF_D)

// Index and counter widths
`define XBUF_ROW_W $clog2(`XBUF_W)
`define XBUF_COL_W $clog2(`XBUF_DEPTH)
`define XBUF_SLOT_W $clog2(`XBUF_H)
`define XBUF_CNT_W ($clog2(`XBUF_DEPTH) + 1)

`endif
